// File: logic/sfm_pkg.sv
`default_nettype none

package sfm_pkg;

    // FP32 format
    localparam int unsigned FP_WIDTH  = 32;
    localparam int unsigned EXP_BITS  = 8;
    localparam int unsigned MANT_BITS = 23;
    localparam int unsigned FP_BIAS   = 127;

    // Mantissa bits kept by the approximate inverter
    localparam int unsigned INV_MANT_BITS = 7;

    // Significand width of the multiplier, hidden bit included
    localparam int unsigned MUL_MANT_BITS = 8;

    // Register stages in every arithmetic pipeline
    localparam int unsigned PIPE_REGS = 2;

    typedef struct packed {
        logic                 sign;
        logic [EXP_BITS-1:0]  exponent;
        logic [MANT_BITS-1:0] mantissa;
    } fp_fields_t;

    // One FP32 word, seen as raw bits or as its fields
    typedef union packed {
        logic [FP_WIDTH-1:0] bits;
        fp_fields_t          f;
    } fp_word_u;

endpackage

`default_nettype wire

// File: logic/sfm_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sfm_stream_if import sfm_pkg::*; ();

    logic     valid;
    logic     ready;
    fp_word_u data;
    logic     last;

    modport src (
        output valid,
        output data,
        output last,
        input  ready
    );

    modport snk (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

// File: logic/sfm_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module sfm_pipeline #(
    parameter int unsigned WIDTH = 1,
    parameter int unsigned DEPTH = 1
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             clear_i,
    input  logic             valid_i,
    output logic             ready_o,
    input  logic [WIDTH-1:0] data_i,
    output logic             valid_o,
    input  logic             ready_i,
    output logic [WIDTH-1:0] data_o
);

    logic [DEPTH-1:0]             vld_q;
    logic [DEPTH-1:0][WIDTH-1:0]  dat_q;
    logic [DEPTH:0]               rdy;

    // A stage can take a word when empty or when its successor moves on
    assign rdy[DEPTH] = ready_i;
    for (genvar g = 0; g < DEPTH; g++) begin : g_rdy
        assign rdy[g] = ~vld_q[g] | rdy[g+1];
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i) begin
            vld_q <= '0;
        end else begin
            if (rdy[0]) begin
                vld_q[0] <= valid_i;
            end
            for (int k = 1; k < DEPTH; k++) begin
                if (rdy[k]) begin
                    vld_q[k] <= vld_q[k-1];
                end
            end
        end
    end

    // Payload only moves together with a valid word
    always_ff @(posedge clk_i) begin
        if (rdy[0] && valid_i) begin
            dat_q[0] <= data_i;
        end
        for (int k = 1; k < DEPTH; k++) begin
            if (rdy[k] && vld_q[k-1]) begin
                dat_q[k] <= dat_q[k-1];
            end
        end
    end

    assign ready_o = rdy[0];
    assign valid_o = vld_q[DEPTH-1];
    assign data_o  = dat_q[DEPTH-1];

endmodule

`default_nettype wire

// File: logic/sfm_den_inverter.sv
`timescale 1ns/1ps
`default_nettype none

module sfm_den_inverter import sfm_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      clear_i,
    sfm_stream_if.snk den_if,
    sfm_stream_if.src inv_if
);

    fp_word_u                   den;
    fp_word_u                   res;
    logic [INV_MANT_BITS-1:0]   sel;
    logic [INV_MANT_BITS-1:0]   sel_n;
    logic [2*INV_MANT_BITS-2:0] prod;
    logic [FP_WIDTH:0]          pipe_out;

    assign den   = den_if.data;
    assign sel   = den.f.mantissa[MANT_BITS-1 -: INV_MANT_BITS];
    assign sel_n = ~sel;

    // Coarse estimate of the reciprocal mantissa
    assign prod = (2*INV_MANT_BITS-1)'(sel_n >> 1) * (2*INV_MANT_BITS-1)'(sel_n);

    always_comb begin
        res.f.sign = den.f.sign;
        if (sel == '0) begin
            // Exact power of two
            res.f.exponent = EXP_BITS'(2 * FP_BIAS) - den.f.exponent;
            res.f.mantissa = '0;
        end else begin
            res.f.exponent = EXP_BITS'(2 * FP_BIAS - 1) - den.f.exponent;
            res.f.mantissa = {prod[2*INV_MANT_BITS-2 -: INV_MANT_BITS],
                              {(MANT_BITS - INV_MANT_BITS){1'b0}}};
        end
    end

    sfm_pipeline #(
        .WIDTH (FP_WIDTH + 1),
        .DEPTH (PIPE_REGS)
    ) u_pipe (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .clear_i (clear_i),
        .valid_i (den_if.valid),
        .ready_o (den_if.ready),
        .data_i  ({den_if.last, res.bits}),
        .valid_o (inv_if.valid),
        .ready_i (inv_if.ready),
        .data_o  (pipe_out)
    );

    assign inv_if.data = pipe_out[FP_WIDTH-1:0];
    assign inv_if.last = pipe_out[FP_WIDTH];

endmodule

`default_nettype wire

// File: logic/sfm_fp_mul.sv
`timescale 1ns/1ps
`default_nettype none

module sfm_fp_mul import sfm_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                clear_i,
    sfm_stream_if.snk           a_if,
    input  fp_word_u            recip_i,
    output logic                out_valid_o,
    input  logic                out_ready_i,
    output logic [FP_WIDTH-1:0] out_data_o,
    output logic                out_last_o
);

    fp_word_u                   a;
    fp_word_u                   prod_w;
    logic [MUL_MANT_BITS-1:0]   sig_a;
    logic [MUL_MANT_BITS-1:0]   sig_b;
    logic [2*MUL_MANT_BITS-1:0] sig_prod;
    logic                       norm;
    logic [MUL_MANT_BITS-2:0]   frac;
    logic [EXP_BITS+1:0]        exp_raw;
    logic                       is_zero;

    assign a = a_if.data;

    // 1.7 significands with the hidden bit restored
    assign sig_a    = {1'b1, a.f.mantissa[MANT_BITS-1 -: MUL_MANT_BITS-1]};
    assign sig_b    = {1'b1, recip_i.f.mantissa[MANT_BITS-1 -: MUL_MANT_BITS-1]};
    assign sig_prod = (2*MUL_MANT_BITS)'(sig_a) * (2*MUL_MANT_BITS)'(sig_b);

    // Product in [2,4) needs one right shift
    assign norm = sig_prod[2*MUL_MANT_BITS-1];
    assign frac = norm ? sig_prod[2*MUL_MANT_BITS-2 -: MUL_MANT_BITS-1]
                       : sig_prod[2*MUL_MANT_BITS-3 -: MUL_MANT_BITS-1];

    // Biased sum still carries one extra bias here
    assign exp_raw = {2'b00, a.f.exponent} + {2'b00, recip_i.f.exponent}
                   + {{(EXP_BITS+1){1'b0}}, norm};

    assign is_zero = (a.f.exponent == '0) || (recip_i.f.exponent == '0)
                  || (exp_raw <= (EXP_BITS+2)'(FP_BIAS));

    always_comb begin
        prod_w.f.sign = a.f.sign ^ recip_i.f.sign;
        if (is_zero) begin
            prod_w.f.exponent = '0;
            prod_w.f.mantissa = '0;
        end else begin
            prod_w.f.exponent = EXP_BITS'(exp_raw - (EXP_BITS+2)'(FP_BIAS));
            prod_w.f.mantissa = {frac, {(MANT_BITS - MUL_MANT_BITS + 1){1'b0}}};
        end
    end

    sfm_pipeline #(
        .WIDTH (FP_WIDTH + 1),
        .DEPTH (PIPE_REGS)
    ) u_pipe (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .clear_i (clear_i),
        .valid_i (a_if.valid),
        .ready_o (a_if.ready),
        .data_i  ({a_if.last, prod_w.bits}),
        .valid_o (out_valid_o),
        .ready_i (out_ready_i),
        .data_o  ({out_last_o, out_data_o})
    );

endmodule

`default_nettype wire

// File: logic/sfm_norm_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sfm_norm_ctrl import sfm_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      clear_i,
    sfm_stream_if.snk in_if,
    sfm_stream_if.src den_if,
    sfm_stream_if.snk inv_if,
    sfm_stream_if.src num_if,
    output fp_word_u  recip_o
);

    // Idle is encoded as neither wait nor run
    logic     wait_q;
    logic     run_q;
    logic     idle;
    fp_word_u recip_q;

    assign idle = ~wait_q & ~run_q;

    // Both branches see the input word and only valid is steered
    assign den_if.data  = in_if.data;
    assign den_if.last  = in_if.last;
    assign den_if.valid = idle & in_if.valid;

    assign num_if.data  = in_if.data;
    assign num_if.last  = in_if.last;
    assign num_if.valid = run_q & in_if.valid;

    // Input stalls while the reciprocal is on its way
    assign in_if.ready  = (idle & den_if.ready) | (run_q & num_if.ready);
    assign inv_if.ready = wait_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i) begin
            wait_q  <= 1'b0;
            run_q   <= 1'b0;
            recip_q <= '0;
        end else begin
            if (den_if.valid && den_if.ready) begin
                wait_q <= 1'b1;
            end
            if (wait_q && inv_if.valid) begin
                wait_q  <= 1'b0;
                run_q   <= 1'b1;
                recip_q <= inv_if.data;
            end
            // Last numerator closes the group
            if (num_if.valid && num_if.ready && num_if.last) begin
                run_q <= 1'b0;
            end
        end
    end

    assign recip_o = recip_q;

endmodule

`default_nettype wire

// File: logic/sfm_norm_top.sv
`timescale 1ns/1ps
`default_nettype none

module sfm_norm_top import sfm_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                clear_i,
    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  logic [FP_WIDTH-1:0] in_data_i,
    input  logic                in_last_i,
    output logic                out_valid_o,
    input  logic                out_ready_i,
    output logic [FP_WIDTH-1:0] out_data_o,
    output logic                out_last_o
);

    sfm_stream_if in_s ();
    sfm_stream_if den_s ();
    sfm_stream_if inv_s ();
    sfm_stream_if mul_s ();

    fp_word_u recip;

    assign in_s.valid = in_valid_i;
    assign in_s.data  = in_data_i;
    assign in_s.last  = in_last_i;
    assign in_ready_o = in_s.ready;

    sfm_norm_ctrl u_ctrl (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .clear_i (clear_i),
        .in_if   (in_s),
        .den_if  (den_s),
        .inv_if  (inv_s),
        .num_if  (mul_s),
        .recip_o (recip)
    );

    sfm_den_inverter u_inv (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .clear_i (clear_i),
        .den_if  (den_s),
        .inv_if  (inv_s)
    );

    // Numerator times the reciprocal held for the group
    sfm_fp_mul u_mul (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .clear_i     (clear_i),
        .a_if        (mul_s),
        .recip_i     (recip),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (out_data_o),
        .out_last_o  (out_last_o)
    );

endmodule

`default_nettype wire

// File: tests/sfm_norm_assert.sv
`timescale 1ns/1ps
`default_nettype none

module sfm_norm_assert (
    input logic        clk_i,
    input logic        rst_n_i,
    input logic        clear_i,
    input logic        in_ready_o,
    input logic        out_valid_o,
    input logic        out_ready_i,
    input logic [31:0] out_data_o,
    input logic        out_last_o
);

    // Stalled output word holds still
    a_out_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i || clear_i)
        out_valid_o && !out_ready_i |=>
            out_valid_o && $stable(out_data_o) && $stable(out_last_o)
    ) else $error("output word changed while stalled");

    a_reset_empty: assert property (
        @(posedge clk_i) !rst_n_i |=> !out_valid_o
    ) else $error("out_valid_o high after reset");

    a_clear_ready: assert property (
        @(posedge clk_i) rst_n_i && clear_i |=> in_ready_o
    ) else $error("in_ready_o low after clear");

endmodule

bind sfm_norm_top sfm_norm_assert u_assert (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clear_i     (clear_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o),
    .out_last_o  (out_last_o)
);

`default_nettype wire

// File: tests/sfm_norm_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sfm_norm_tb;

    localparam int TIMEOUT = 300;

    logic        clk_i;
    logic        rst_n_i;
    logic        clear_i;
    logic        in_valid_i;
    logic        in_ready_o;
    logic [31:0] in_data_i;
    logic        in_last_i;
    logic        out_valid_o;
    logic        out_ready_i;
    logic [31:0] out_data_o;
    logic        out_last_o;

    int unsigned seed   = 47980;
    int          errors = 0;
    int          passed = 0;
    int          failed = 0;

    sfm_norm_top DUT (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .clear_i     (clear_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (in_data_i),
        .in_last_i   (in_last_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (out_data_o),
        .out_last_o  (out_last_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic int unsigned lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Positive FP32 value with exponent in [lo, lo+span)
    function automatic logic [31:0] rand_fp(input int unsigned lo, input int unsigned span);
        int unsigned r;
        int unsigned ex;
        r  = lcg_next();
        ex = lo + (r >> 8) % span;
        r  = lcg_next();
        return {1'b0, ex[7:0], r[22:0]};
    endfunction

    // Approximate reciprocal from the top 7 mantissa bits
    function automatic logic [31:0] inv_model(input logic [31:0] d);
        logic [6:0]  s;
        logic [13:0] p;
        logic [7:0]  e;
        s = ~d[22:16];
        if (d[22:16] == 7'd0) begin
            e = 8'd254 - d[30:23];
            return {d[31], e, 23'd0};
        end
        p = {7'd0, s >> 1} * {7'd0, s};
        e = 8'd253 - d[30:23];
        return {d[31], e, p[12:6], 16'd0};
    endfunction

    // 1.7 x 1.7 significand product, truncated to 7 fraction bits
    function automatic logic [31:0] mul_model(input logic [31:0] a, input logic [31:0] r);
        logic [15:0] p;
        logic [6:0]  frac;
        logic        sgn;
        int          e;
        sgn = a[31] ^ r[31];
        p   = {8'd0, 1'b1, a[22:16]} * {8'd0, 1'b1, r[22:16]};
        e   = int'(a[30:23]) + int'(r[30:23]) - 127;
        if (p[15]) begin
            frac = p[14:8];
            e    = e + 1;
        end else begin
            frac = p[13:7];
        end
        if (a[30:23] == 8'd0 || r[30:23] == 8'd0 || e < 1) begin
            return {sgn, 31'd0};
        end
        return {sgn, e[7:0], frac, 16'd0};
    endfunction

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            passed++;
            $display("%s: pass", name);
        end else begin
            failed++;
            $display("%s: fail with %0d errors", name, errors - err_before);
        end
    endtask

    // Sends one denominator and its numerators, checks every output in order
    task automatic run_group(input logic [31:0] den, input logic [31:0] nums[$],
                             input bit rand_ready, input bit check_lat);
        logic [32:0] exp_q[$];
        int          acc_q[$];
        logic [32:0] e;
        logic [31:0] recip;
        int unsigned rnd;
        int          sent;
        int          got;
        int          cyc;
        int          acc;
        int          last_acc;
        recip = inv_model(den);
        foreach (nums[i]) begin
            exp_q.push_back({i == nums.size() - 1, mul_model(nums[i], recip)});
        end
        sent     = -1;
        got      = 0;
        cyc      = 0;
        last_acc = 0;
        while (got < nums.size() && cyc < TIMEOUT) begin
            @(negedge clk_i);
            rnd        = lcg_next();
            in_valid_i = (sent < nums.size());
            in_data_i  = (sent < 0) ? den : nums[(sent < nums.size()) ? sent : 0];
            in_last_i  = (sent == nums.size() - 1);
            out_ready_i = rand_ready ? rnd[16] : 1'b1;
            #1;
            if (in_valid_i && in_ready_o) begin
                if (sent >= 0) begin
                    if (check_lat && sent >= 1 && cyc != last_acc + 1) begin
                        errors++;
                        $display("numerator %0d was not accepted back to back", sent);
                    end
                    acc_q.push_back(cyc);
                    last_acc = cyc;
                end
                sent++;
            end
            if (out_valid_o && out_ready_i) begin
                e   = exp_q.pop_front();
                acc = acc_q.pop_front();
                if (out_data_o !== e[31:0] || out_last_o !== e[32]) begin
                    errors++;
                    $display("** Error at %0t: output %0d is %h last %b, expected %h last %b",
                             $time, got, out_data_o, out_last_o, e[31:0], e[32]);
                end
                if (check_lat && cyc - acc != 2) begin
                    errors++;
                    $display("** Error at %0t: output %0d latency %0d cycles, expected 2",
                             $time, got, cyc - acc);
                end
                got++;
            end
            cyc++;
        end
        if (got < nums.size()) begin
            errors++;
            $display("Timeout: only %0d of %0d outputs arrived", got, nums.size());
        end
        // No extra words, and the controller is idle again
        repeat (3) begin
            @(negedge clk_i);
            in_valid_i  = 1'b0;
            out_ready_i = 1'b1;
            #1;
            if (out_valid_o || !in_ready_o) begin
                errors++;
                $display("** Error at %0t: extra output or busy input after the group", $time);
            end
        end
    endtask

    task automatic test_power_of_two();
        logic [31:0] nums[$];
        int          err0;
        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            nums.push_back(rand_fp(120, 15));
        end
        run_group(32'h4100_0000, nums, 1'b0, 1'b0);
        report_test("power-of-two denominator", err0);
    endtask

    task automatic test_random_groups();
        logic [31:0] nums[$];
        int          err0;
        int          n;
        err0 = errors;
        for (int g = 0; g < 4; g++) begin
            nums.delete();
            n = 1 + (lcg_next() >> 8) % 6;
            for (int i = 0; i < n; i++) begin
                nums.push_back(rand_fp(120, 15));
            end
            run_group(rand_fp(120, 15), nums, 1'b0, 1'b0);
        end
        report_test("random groups", err0);
    endtask

    task automatic test_back_pressure();
        logic [31:0] nums[$];
        int          err0;
        err0 = errors;
        for (int i = 0; i < 10; i++) begin
            nums.push_back(rand_fp(120, 15));
        end
        run_group(rand_fp(120, 15), nums, 1'b1, 1'b0);
        report_test("back-pressure", err0);
    endtask

    task automatic test_throughput();
        logic [31:0] nums[$];
        int          err0;
        err0 = errors;
        for (int i = 0; i < 6; i++) begin
            nums.push_back(rand_fp(120, 15));
        end
        run_group(rand_fp(120, 15), nums, 1'b0, 1'b1);
        report_test("throughput and latency", err0);
    endtask

    task automatic test_sign_and_zero();
        logic [31:0] nums[$];
        int          err0;
        err0 = errors;
        nums = '{32'hC040_0000, 32'h0000_0000, 32'h8000_0000, 32'h3F80_0000};
        run_group(rand_fp(120, 15), nums, 1'b0, 1'b0);
        // Negative denominator flips every sign
        nums = '{32'h4040_0000, 32'hBFA0_0000, 32'h0000_0000};
        run_group(32'hC2C8_0000, nums, 1'b0, 1'b0);
        report_test("sign and zero", err0);
    endtask

    task automatic test_clear_mid_group();
        logic [31:0] nums[$];
        logic [31:0] den;
        logic [31:0] num;
        int          err0;
        int          accepted;
        int          wait_cnt;
        err0     = errors;
        den      = rand_fp(120, 15);
        num      = rand_fp(120, 15);
        accepted = -1;
        wait_cnt = 0;
        while (accepted < 2 && wait_cnt < TIMEOUT) begin
            @(negedge clk_i);
            in_valid_i  = 1'b1;
            in_data_i   = (accepted < 0) ? den : num;
            in_last_i   = 1'b0;
            out_ready_i = 1'b0;
            #1;
            if (in_ready_o) begin
                accepted++;
            end
            wait_cnt++;
        end
        if (accepted < 2) begin
            errors++;
            $display("Timeout: the group was not accepted before the clear");
        end
        @(negedge clk_i);
        in_valid_i = 1'b0;
        clear_i    = 1'b1;
        #1;
        if (!out_valid_o) begin
            errors++;
            $display("** Error at %0t: no pending output before the clear", $time);
        end
        @(negedge clk_i);
        clear_i = 1'b0;
        #1;
        if (out_valid_o !== 1'b0 || in_ready_o !== 1'b1) begin
            errors++;
            $display("** Error at %0t: after clear out_valid %b in_ready %b, expected 0 1",
                     $time, out_valid_o, in_ready_o);
        end
        for (int i = 0; i < 3; i++) begin
            nums.push_back(rand_fp(120, 15));
        end
        run_group(rand_fp(120, 15), nums, 1'b0, 1'b0);
        report_test("clear mid-group", err0);
    endtask

    initial begin
        rst_n_i     = 1'b0;
        clear_i     = 1'b0;
        in_valid_i  = 1'b0;
        in_data_i   = '0;
        in_last_i   = 1'b0;
        out_ready_i = 1'b1;
        repeat (3) @(negedge clk_i);
        rst_n_i = 1'b1;

        test_power_of_two();
        test_random_groups();
        test_back_pressure();
        test_throughput();
        test_sign_and_zero();
        test_clear_mid_group();

        $display("Tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
logic/sfm_pkg.sv
logic/sfm_stream_if.sv
logic/sfm_pipeline.sv
logic/sfm_den_inverter.sv
logic/sfm_fp_mul.sv
logic/sfm_norm_ctrl.sv
logic/sfm_norm_top.sv
tests/sfm_norm_assert.sv
tests/sfm_norm_tb.sv

// File: Makefile
# Verilator build and run of the softmax normalization stage

VERILATOR ?= verilator
TOP       ?= sfm_norm_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench, output in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
